// ==== mycpu.f ====
verilog/common.sv
verilog/bus.sv
verilog/handshake.sv
verilog/decoder.sv
verilog/datapath.sv
verilog/rfwrite_queue.sv
verilog/mycpu.sv
tb/mycpu_properties.sv
tb/tb_mycpu.sv

// ==== Makefile ====
TOP = tb_mycpu

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): mycpu.f verilog/*.sv tb/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f mycpu.f -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f mycpu.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== tb/tb_mycpu.sv ====
// mycpu testbench
`timescale 1ns/1ps
module tb_mycpu;

    localparam int NPROG = 204;
    localparam int CYCLE_LIMIT = 200 * 20 + 500;

    logic clk;
    logic rst;
    logic inst_req, inst_wr, inst_addr_ok, inst_data_ok;
    logic [1:0] inst_size;
    common::word_t inst_addr, inst_wdata, inst_rdata;
    logic data_req, data_wr, data_addr_ok, data_data_ok;
    logic [1:0] data_size;
    common::word_t data_addr, data_wdata, data_rdata;
    common::word_t debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    common::creg_addr_t debug_wb_rf_wnum;

    integer seed;
    int cycles;
    common::word_t imem [256];
    common::word_t dmem [256];
    common::word_t ref_mem [256];
    common::word_t ref_regs [32];
    // expected trace in program order
    common::word_t exp_pc [$];
    common::creg_addr_t exp_reg [$];
    common::word_t exp_val [$];
    bit exp_ld [$];
    bit matched [$];
    common::word_t exp_fetch [$];
    common::word_t exp_daddr [$];
    logic exp_dwr [$];
    common::word_t exp_dwdata [$];
    int head, seen, f_idx, d_idx;
    // alu writes traced ahead of an older pending load
    int overtakes;
    int i_phase, i_cnt, d_phase, d_cnt;
    common::word_t i_addr_q, d_addr_q;

    mycpu dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycles++;

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(string name, common::word_t got, common::word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(string name, common::creg_addr_t got, common::creg_addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_size(string name, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // address-dependent pattern, every word differs
    function automatic common::word_t fill_word(common::word_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic common::word_t to_phys(common::word_t va);
        common::word_t pa;
        pa = va;
        if (va[31:28] == 4'h8 || va[31:28] == 4'ha) begin
            pa[31:28] = 4'h0;
        end else if (va[31:28] == 4'h9 || va[31:28] == 4'hb) begin
            pa[31:28] = 4'h1;
        end
        return pa;
    endfunction

    function automatic common::word_t enc_r(logic [5:0] fn, int rs, int rt, int rd);
        return {common::OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic common::word_t enc_i(logic [5:0] opc, int rs, int rt, logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    // instruction memory sits at physical 0x1fc00000
    function automatic common::word_t fetch_word(common::word_t addr);
        common::word_t off;
        off = (addr & 32'h1fffffff) - 32'h1fc00000;
        return (off[31:10] != 0) ? 32'h0 : imem[off[9:2]];
    endfunction

    task automatic gen_program();
        int kind, rs, rt, rd, off;
        foreach (imem[k]) imem[k] = 32'h0;
        // r1 and r2 hold the kseg0 and kseg1 data bases
        imem[0] = enc_i(common::OPC_LUI, 0, 1, 16'h8000);
        imem[1] = enc_i(common::OPC_ADDIU, 1, 1, 16'h1000);
        imem[2] = enc_i(common::OPC_LUI, 0, 2, 16'ha000);
        imem[3] = enc_i(common::OPC_ADDIU, 2, 2, 16'h1000);
        for (int k = 4; k < NPROG; k++) begin
            kind = $random(seed) & 15;
            rs = $random(seed) & 15;
            rt = $random(seed) & 15;
            rd = $random(seed) & 15;
            if (rd == 1 || rd == 2) rd = 0;
            case (kind)
                2: imem[k] = enc_r(common::FN_SUBU, rs, rt, rd);
                3: imem[k] = enc_r(common::FN_AND, rs, rt, rd);
                4: imem[k] = enc_r(common::FN_OR, rs, rt, rd);
                5: imem[k] = enc_r(common::FN_XOR, rs, rt, rd);
                6: imem[k] = enc_r(common::FN_SLT, rs, rt, rd);
                7, 8: imem[k] = enc_i(common::OPC_ADDIU, rs, rd, 16'($random(seed)));
                9: imem[k] = enc_i(common::OPC_LUI, 0, rd, 16'($random(seed)));
                10, 11: imem[k] = enc_i(common::OPC_LW, 1 + (rs & 1), rd,
                                        16'(($random(seed) & 255) * 4));
                12: imem[k] = enc_i(common::OPC_SW, 1 + (rs & 1), rt,
                                    16'(($random(seed) & 255) * 4));
                13, 14: begin
                    // forward only, never past the program end
                    off = $random(seed) & 3;
                    if (off > NPROG - 1 - k) off = NPROG - 1 - k;
                    if ((rd & 1) == 1) rt = rs;
                    imem[k] = enc_i((kind == 13) ? common::OPC_BEQ : common::OPC_BNE,
                                    rs, rt, 16'(off));
                end
                default: imem[k] = enc_r(common::FN_ADDU, rs, rt, rd);
            endcase
        end
    endtask

    function automatic void run_reference();
        int idx, rs, rt, rd, dst;
        common::word_t w, a, b, simm, val, pa;
        logic wr, ld;
        foreach (ref_regs[r]) ref_regs[r] = 32'h0;
        foreach (ref_mem[m]) ref_mem[m] = fill_word(32'h1000 + 32'(m * 4));
        idx = 0;
        while (idx < NPROG) begin
            w = imem[idx];
            exp_fetch.push_back(common::RESET_PC + 32'(idx * 4));
            rs = int'(w[25:21]);
            rt = int'(w[20:16]);
            rd = int'(w[15:11]);
            a = ref_regs[rs];
            b = ref_regs[rt];
            simm = {{16{w[15]}}, w[15:0]};
            pa = to_phys(a + simm);
            wr = 1'b1;
            ld = 1'b0;
            dst = rt;
            val = 32'h0;
            case (w[31:26])
                common::OPC_SPECIAL: begin
                    dst = rd;
                    case (w[5:0])
                        common::FN_ADDU: val = a + b;
                        common::FN_SUBU: val = a - b;
                        common::FN_AND: val = a & b;
                        common::FN_OR: val = a | b;
                        common::FN_XOR: val = a ^ b;
                        common::FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                common::OPC_ADDIU: val = a + simm;
                common::OPC_LUI: val = {w[15:0], 16'h0000};
                common::OPC_LW: begin
                    exp_daddr.push_back(pa);
                    exp_dwr.push_back(1'b0);
                    exp_dwdata.push_back(32'h0);
                    val = ref_mem[pa[9:2]];
                    ld = 1'b1;
                end
                common::OPC_SW: begin
                    exp_daddr.push_back(pa);
                    exp_dwr.push_back(1'b1);
                    exp_dwdata.push_back(b);
                    ref_mem[pa[9:2]] = b;
                    wr = 1'b0;
                end
                common::OPC_BEQ: begin
                    wr = 1'b0;
                    if (a == b) idx += int'(simm);
                end
                common::OPC_BNE: begin
                    wr = 1'b0;
                    if (a != b) idx += int'(simm);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 0) begin
                exp_pc.push_back(exp_fetch[exp_fetch.size() - 1]);
                exp_reg.push_back(5'(dst));
                exp_val.push_back(val);
                exp_ld.push_back(ld);
                matched.push_back(1'b0);
                ref_regs[dst] = val;
            end
            idx++;
        end
    endfunction

    // a pending load may trail younger alu writes
    task automatic match_trace();
        int j;
        int hit;
        hit = -1;
        while (head < exp_pc.size() && matched[head]) head++;
        j = head;
        while (hit < 0 && j < exp_pc.size()) begin
            if (!matched[j] && exp_pc[j] == debug_wb_pc) begin
                hit = j;
            end else if (!matched[j] && !exp_ld[j]) begin
                break;
            end
            j++;
        end
        if (hit < 0) begin
            $display("trace write at pc %h is extra or out of program order", debug_wb_pc);
            stop_with_failure();
        end else begin
            check_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_reg[hit]);
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[hit]);
            matched[hit] = 1'b1;
            if (hit > head) overtakes++;
            seen++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && debug_wb_rf_wen != 4'h0) match_trace();
    end

    // instruction and data sram models
    always @(negedge clk) begin
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        if (rst) begin
            i_phase = 0;
            i_cnt = $random(seed) & 7;
        end else if (i_phase == 0) begin
            if (inst_req && i_cnt == 0) begin
                inst_addr_ok = 1'b1;
                i_addr_q = inst_addr;
                if (f_idx < exp_fetch.size()) begin
                    check_word("inst_addr", inst_addr, exp_fetch[f_idx]);
                end
                check_bit("inst_wr", inst_wr, 1'b0);
                check_size("inst_size", inst_size, 2'b10);
                check_word("inst_wdata", inst_wdata, 32'h0);
                f_idx++;
                i_cnt = $random(seed) & 7;
                i_phase = 1;
            end else if (inst_req) begin
                i_cnt--;
            end
        end else if (i_cnt == 0) begin
            inst_data_ok = 1'b1;
            inst_rdata = fetch_word(i_addr_q);
            i_cnt = $random(seed) & 7;
            i_phase = 0;
        end else begin
            i_cnt--;
        end

        // data side
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        if (rst) begin
            d_phase = 0;
            d_cnt = $random(seed) & 7;
        end else if (d_phase == 0) begin
            if (data_req && d_cnt == 0) begin
                data_addr_ok = 1'b1;
                if (d_idx >= exp_daddr.size()) begin
                    $display("data access at %h beyond the expected accesses", data_addr);
                    stop_with_failure();
                end
                check_word("data_addr", data_addr, exp_daddr[d_idx]);
                check_bit("data_wr", data_wr, exp_dwr[d_idx]);
                check_size("data_size", data_size, 2'b10);
                if (data_wr) begin
                    check_word("data_wdata", data_wdata, exp_dwdata[d_idx]);
                end
                d_idx++;
                d_addr_q = data_addr;
                if (data_wr) dmem[data_addr[9:2]] = data_wdata;
                d_cnt = $random(seed) & 7;
                d_phase = 1;
            end else if (data_req) begin
                d_cnt--;
            end
        end else if (d_cnt == 0) begin
            data_data_ok = 1'b1;
            data_rdata = dmem[d_addr_q[9:2]];
            d_cnt = $random(seed) & 7;
            d_phase = 0;
        end else begin
            d_cnt--;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 27002;
        cycles = 0;
        head = 0;
        seen = 0;
        f_idx = 0;
        d_idx = 0;
        overtakes = 0;
        inst_rdata = 32'h0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        data_rdata = 32'h0;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        foreach (dmem[m]) dmem[m] = fill_word(32'h1000 + 32'(m * 4));
        gen_program();
        run_reference();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        while (seen < exp_pc.size() && cycles < CYCLE_LIMIT) @(posedge clk);
        if (seen < exp_pc.size()) begin
            $display("timeout after %0d cycles, %0d of %0d trace writes seen",
                     cycles, seen, exp_pc.size());
            stop_with_failure();
        end else begin
            // let any stray trace entry or access show up
            repeat (40) @(posedge clk);
            if (d_idx != exp_daddr.size()) begin
                $display("only %0d of %0d data accesses arrived", d_idx, exp_daddr.size());
                stop_with_failure();
            end
            if (overtakes == 0) begin
                $display("no alu write retired while an older load was pending");
                stop_with_failure();
            end
            foreach (dmem[m]) check_word("data memory word", dmem[m], ref_mem[m]);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== tb/mycpu_properties.sv ====
// bus protocol assertions
`timescale 1ns/1ps
module mycpu_properties (
    input logic clk,
    input logic rst,
    input logic inst_req,
    input common::word_t inst_addr,
    input logic inst_addr_ok,
    input logic inst_data_ok,
    input logic data_req,
    input logic data_wr,
    input common::word_t data_addr,
    input common::word_t data_wdata,
    input logic data_addr_ok,
    input logic data_data_ok
);

    // address accepted, data not yet returned
    logic i_out;
    logic d_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            i_out <= 1'b0;
            d_out <= 1'b0;
        end else begin
            if (inst_req && inst_addr_ok) begin
                i_out <= 1'b1;
            end else if (inst_data_ok) begin
                i_out <= 1'b0;
            end
            if (data_req && data_addr_ok) begin
                d_out <= 1'b1;
            end else if (data_data_ok) begin
                d_out <= 1'b0;
            end
        end
    end

    a_inst_req_held: assert property (@(posedge clk) disable iff (rst)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr))
        else $error("inst_req dropped or address changed before addr_ok");

    a_data_req_held: assert property (@(posedge clk) disable iff (rst)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr)
            && $stable(data_wr) && $stable(data_wdata))
        else $error("data_req dropped or request changed before addr_ok");

    a_inst_single: assert property (@(posedge clk) disable iff (rst) i_out |-> !inst_req)
        else $error("second instruction request before data_ok");

    a_data_single: assert property (@(posedge clk) disable iff (rst) d_out |-> !data_req)
        else $error("second data request before data_ok");

endmodule

bind mycpu mycpu_properties u_properties (
    .clk,
    .rst,
    .inst_req,
    .inst_addr,
    .inst_addr_ok,
    .inst_data_ok,
    .data_req,
    .data_wr,
    .data_addr,
    .data_wdata,
    .data_addr_ok,
    .data_data_ok
);

// ==== verilog/mycpu.sv ====
// cpu top with sram-like buses
`timescale 1ns/1ps
module mycpu #(
    parameter logic DO_ADDR_TRANSLATION = 1'b1
) (
    input  logic clk,
    input  logic rst,

    output logic inst_req,
    output logic inst_wr,
    output logic [1:0] inst_size,
    output common::word_t inst_addr,
    output common::word_t inst_wdata,
    input  common::word_t inst_rdata,
    input  logic inst_addr_ok,
    input  logic inst_data_ok,

    output logic data_req,
    output logic data_wr,
    output logic [1:0] data_size,
    output common::word_t data_addr,
    output common::word_t data_wdata,
    input  common::word_t data_rdata,
    input  logic data_addr_ok,
    input  logic data_data_ok,

    // retire trace
    output common::word_t debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output common::creg_addr_t debug_wb_rf_wnum,
    output common::word_t debug_wb_rf_wdata
);

    bus::m_r_t mread;
    bus::m_w_t mwrite;
    common::rf_w_t [common::ISSUE_WIDTH-1:0] rfw_lanes;
    common::word_t [common::ISSUE_WIDTH-1:0] pc_lanes;
    logic [common::ISSUE_WIDTH-1:0] retire;
    common::rf_w_t rfw_q;
    logic q_valid;
    logic q_room;
    logic fetch_req;
    logic i_data_ok;
    logic d_data_ok;
    common::word_t vaddr;

    datapath u_datapath (
        .clk,
        .rst,
        .instr_(inst_rdata),
        .i_data_ok,
        .d_data_ok,
        .rd(data_rdata),
        .queue_room(q_room),
        .pc(inst_addr),
        .fetch_req,
        .mread,
        .mwrite,
        .rfwrite(rfw_lanes),
        .wb_pc(pc_lanes)
    );

    // fetch port is read-only
    assign inst_wr = 1'b0;
    assign inst_size = bus::SIZE_WORD;
    assign inst_wdata = '0;

    handshake i_handshake (
        .clk,
        .rst,
        .cpu_req(fetch_req),
        .addr_ok(inst_addr_ok),
        .data_ok(inst_data_ok),
        .req(inst_req),
        .cpu_data_ok(i_data_ok)
    );

    assign data_wr = mwrite.wen;
    assign vaddr = mwrite.wen ? mwrite.addr : mread.addr;
    assign data_size = mwrite.wen ? mwrite.size : mread.size;
    assign data_wdata = mwrite.wd;

    if (DO_ADDR_TRANSLATION == 1'b1) begin : g_xlate
        // kseg0 and kseg1 fold onto the low physical space
        always_comb begin
            data_addr = vaddr;
            case (vaddr[31:28])
                4'h8, 4'ha: data_addr[31:28] = 4'h0;
                4'h9, 4'hb: data_addr[31:28] = 4'h1;
                default: ;
            endcase
        end
    end else begin : g_no_xlate
        assign data_addr = vaddr;
    end

    handshake d_handshake (
        .clk,
        .rst,
        .cpu_req(mread.ren | mwrite.wen),
        .addr_ok(data_addr_ok),
        .data_ok(data_data_ok),
        .req(data_req),
        .cpu_data_ok(d_data_ok)
    );

    always_comb begin
        for (int i = 0; i < common::ISSUE_WIDTH; i++) begin
            retire[i] = rfw_lanes[i].wen;
        end
    end

    rfwrite_queue u_rfwrite_queue (
        .clk,
        .rst,
        .rfw(rfw_lanes),
        .rt_pc(pc_lanes),
        .retire,
        .rfw_out(rfw_q),
        .rt_pc_out(debug_wb_pc),
        .out_valid(q_valid),
        .room(q_room)
    );

    // register 0 never shows up as a write
    assign debug_wb_rf_wen = {4{q_valid && rfw_q.wen && rfw_q.addr != '0}};
    assign debug_wb_rf_wnum = rfw_q.addr;
    assign debug_wb_rf_wdata = rfw_q.wd;

endmodule

// ==== verilog/rfwrite_queue.sv ====
// retire trace queue
`timescale 1ns/1ps
module rfwrite_queue (
    input  logic clk,
    input  logic rst,
    input  common::rf_w_t [common::ISSUE_WIDTH-1:0] rfw,
    input  common::word_t [common::ISSUE_WIDTH-1:0] rt_pc,
    input  logic [common::ISSUE_WIDTH-1:0] retire,
    output common::rf_w_t rfw_out,
    output common::word_t rt_pc_out,
    output logic out_valid,
    output logic room
);

    common::rf_w_t rfw_mem [common::RFQ_DEPTH];
    common::word_t pc_mem [common::RFQ_DEPTH];

    logic [common::RFQ_PTR_W-1:0] wr_ptr;
    logic [common::RFQ_PTR_W-1:0] rd_ptr;
    logic [common::RFQ_PTR_W:0] count;
    logic [common::RFQ_PTR_W:0] push_cnt;
    logic [common::RFQ_PTR_W-1:0] wr_pos [common::ISSUE_WIDTH];

    // valid lanes packed in lane order from wr_ptr
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < common::ISSUE_WIDTH; i++) begin
            wr_pos[i] = wr_ptr + push_cnt[common::RFQ_PTR_W-1:0];
            push_cnt = push_cnt + {{common::RFQ_PTR_W{1'b0}}, retire[i]};
        end
    end

    assign out_valid = (count != '0);
    assign rfw_out = rfw_mem[rd_ptr];
    assign rt_pc_out = pc_mem[rd_ptr];
    // a full dual retire must always fit
    assign room = (count <= (common::RFQ_PTR_W + 1)'(common::RFQ_DEPTH - 2));

    always_ff @(posedge clk) begin
        for (int i = 0; i < common::ISSUE_WIDTH; i++) begin
            if (retire[i]) begin
                rfw_mem[wr_pos[i]] <= rfw[i];
                pc_mem[wr_pos[i]] <= rt_pc[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_cnt[common::RFQ_PTR_W-1:0];
            if (out_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push_cnt - {{common::RFQ_PTR_W{1'b0}}, out_valid};
        end
    end

endmodule

// ==== verilog/datapath.sv ====
// two-lane in-order datapath
`timescale 1ns/1ps
module datapath (
    input  logic clk,
    input  logic rst,
    input  common::word_t instr_,
    input  logic i_data_ok,
    input  logic d_data_ok,
    input  common::word_t rd,
    input  logic queue_room,
    output common::word_t pc,
    output logic fetch_req,
    output bus::m_r_t mread,
    output bus::m_w_t mwrite,
    output common::rf_w_t [common::ISSUE_WIDTH-1:0] rfwrite,
    output common::word_t [common::ISSUE_WIDTH-1:0] wb_pc
);

    common::word_t regs [32];

    // fetched instruction waiting to issue, its pc is the current pc
    common::instr_t ibuf;
    logic ibuf_valid;

    common::op_t op;
    common::creg_addr_t rs;
    common::creg_addr_t rt;
    common::creg_addr_t dst;
    common::word_t imm;
    logic writes_reg;
    logic is_mem;

    common::word_t rs_val;
    common::word_t rt_val;
    common::word_t alu_y;
    common::word_t br_target;
    logic br_taken;
    logic hazard;
    logic stall;
    logic go;

    // memory lane
    logic m_busy;
    logic m_is_store;
    logic ld_done;
    logic ld_pending;
    logic lane1_busy;
    logic lane1_ret;
    common::word_t m_addr;
    common::word_t m_wd;
    common::word_t ld_data;
    common::word_t ld_pc;
    common::creg_addr_t ld_dst;

    decoder u_decoder (
        .instr(ibuf),
        .op,
        .rs,
        .rt,
        .dst,
        .imm,
        .writes_reg,
        .is_mem
    );

    assign rs_val = (rs == '0) ? '0 : regs[rs];
    assign rt_val = (rt == '0) ? '0 : regs[rt];

    // also forms the load/store address
    always_comb begin
        case (op)
            common::OP_ADDU: alu_y = rs_val + rt_val;
            common::OP_SUBU: alu_y = rs_val - rt_val;
            common::OP_AND: alu_y = rs_val & rt_val;
            common::OP_OR: alu_y = rs_val | rt_val;
            common::OP_XOR: alu_y = rs_val ^ rt_val;
            common::OP_SLT: alu_y = {31'b0, $signed(rs_val) < $signed(rt_val)};
            common::OP_ADDIU, common::OP_LW, common::OP_SW: alu_y = rs_val + imm;
            common::OP_LUI: alu_y = imm;
            default: alu_y = '0;
        endcase
    end

    assign br_taken = (op == common::OP_BEQ && rs_val == rt_val)
                   || (op == common::OP_BNE && rs_val != rt_val);
    // no delay slot, offset counts from the next instruction
    assign br_target = pc + 32'd4 + {imm[29:0], 2'b00};

    assign ld_pending = (m_busy && !m_is_store) || ld_done;
    assign lane1_busy = m_busy || ld_done;
    assign hazard = ld_pending
                 && (rs == ld_dst || rt == ld_dst || (writes_reg && dst == ld_dst));
    assign stall = hazard || (is_mem && lane1_busy);
    assign go = ibuf_valid && !stall && queue_room;
    assign lane1_ret = ld_done && queue_room;

    assign fetch_req = !ibuf_valid;

    assign rfwrite[0] = '{wen: go && writes_reg && !is_mem, addr: dst, wd: alu_y};
    assign wb_pc[0] = pc;
    assign rfwrite[1] = '{wen: lane1_ret, addr: ld_dst, wd: ld_data};
    assign wb_pc[1] = ld_pc;

    assign mread = '{ren: m_busy && !m_is_store, addr: m_addr, size: bus::SIZE_WORD};
    assign mwrite = '{wen: m_busy && m_is_store, addr: m_addr, wd: m_wd,
                      size: bus::SIZE_WORD};

    // register file starts from zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < common::ISSUE_WIDTH; i++) begin
                if (rfwrite[i].wen) begin
                    regs[rfwrite[i].addr] <= rfwrite[i].wd;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= common::RESET_PC;
            ibuf_valid <= 1'b0;
            m_busy <= 1'b0;
            m_is_store <= 1'b0;
            ld_done <= 1'b0;
        end else begin
            if (i_data_ok) begin
                ibuf_valid <= 1'b1;
            end else if (go) begin
                ibuf_valid <= 1'b0;
                pc <= br_taken ? br_target : pc + 32'd4;
            end
            if (go && is_mem) begin
                m_busy <= 1'b1;
                m_is_store <= (op == common::OP_SW);
            end else if (d_data_ok) begin
                m_busy <= 1'b0;
            end
            if (d_data_ok && !m_is_store) begin
                ld_done <= 1'b1;
            end else if (lane1_ret) begin
                ld_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_data_ok) begin
            ibuf <= instr_;
        end
        if (go && is_mem) begin
            m_addr <= alu_y;
            m_wd <= rt_val;
            ld_dst <= dst;
            ld_pc <= pc;
        end
        if (d_data_ok) begin
            ld_data <= rd;
        end
    end

endmodule

// ==== verilog/decoder.sv ====
// instruction decoder
`timescale 1ns/1ps
module decoder (
    input  common::instr_t instr,
    output common::op_t op,
    output common::creg_addr_t rs,
    output common::creg_addr_t rt,
    output common::creg_addr_t dst,
    output common::word_t imm,
    output logic writes_reg,
    output logic is_mem
);

    always_comb begin
        op = common::OP_NOP;
        // rs and rt sit in the same bits in both forms
        rs = instr.r.rs;
        rt = instr.r.rt;
        if (instr.r.opcode == common::OPC_SPECIAL) begin
            dst = instr.r.rd;
            case (instr.r.funct)
                common::FN_ADDU: op = common::OP_ADDU;
                common::FN_SUBU: op = common::OP_SUBU;
                common::FN_AND: op = common::OP_AND;
                common::FN_OR: op = common::OP_OR;
                common::FN_XOR: op = common::OP_XOR;
                common::FN_SLT: op = common::OP_SLT;
                default: op = common::OP_NOP;
            endcase
        end else begin
            // immediate forms write rt
            dst = instr.i.rt;
            case (instr.i.opcode)
                common::OPC_ADDIU: op = common::OP_ADDIU;
                common::OPC_LUI: op = common::OP_LUI;
                common::OPC_LW: op = common::OP_LW;
                common::OPC_SW: op = common::OP_SW;
                common::OPC_BEQ: op = common::OP_BEQ;
                common::OPC_BNE: op = common::OP_BNE;
                default: op = common::OP_NOP;
            endcase
        end
    end

    // lui loads the upper half, everything else sign-extends
    assign imm = (op == common::OP_LUI) ? {instr.i.imm, 16'h0000}
                                        : {{16{instr.i.imm[15]}}, instr.i.imm};

    assign writes_reg = op inside {common::OP_ADDU, common::OP_SUBU, common::OP_AND,
                                   common::OP_OR, common::OP_XOR, common::OP_SLT,
                                   common::OP_ADDIU, common::OP_LUI, common::OP_LW};
    assign is_mem = op inside {common::OP_LW, common::OP_SW};

endmodule

// ==== verilog/handshake.sv ====
// sram port handshake
`timescale 1ns/1ps
module handshake (
    input  logic clk,
    input  logic rst,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic cpu_data_ok
);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } state_t;

    state_t state;
    // address phase done, only data outstanding
    logic accepted;

    assign req = (state == S_WAIT) && !accepted;
    assign cpu_data_ok = (state == S_WAIT) && accepted && data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            accepted <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cpu_req) begin
                        state <= S_WAIT;
                        accepted <= 1'b0;
                    end
                end
                S_WAIT: begin
                    if (req && addr_ok) begin
                        accepted <= 1'b1;
                    end
                    if (cpu_data_ok) begin
                        state <= S_IDLE;
                        accepted <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/bus.sv ====
// memory request types
package bus;

    localparam logic [1:0] SIZE_WORD = 2'b10;

    // load request, held until the data returns
    typedef struct packed {
        logic ren;
        common::word_t addr;
        logic [1:0] size;
    } m_r_t;

    // store request
    typedef struct packed {
        logic wen;
        common::word_t addr;
        common::word_t wd;
        logic [1:0] size;
    } m_w_t;

endpackage

// ==== verilog/common.sv ====
// core types and constants
package common;

    typedef logic [31:0] word_t;
    typedef logic [4:0] creg_addr_t;

    localparam int ISSUE_WIDTH = 2;
    localparam word_t RESET_PC = 32'hbfc00000;

    // trace queue sizing
    localparam int RFQ_DEPTH = 4;
    localparam int RFQ_PTR_W = $clog2(RFQ_DEPTH);

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ = 6'h04;
    localparam logic [5:0] OPC_BNE = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LUI = 6'h0f;
    localparam logic [5:0] OPC_LW = 6'h23;
    localparam logic [5:0] OPC_SW = 6'h2b;

    // special function codes
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic wen;
        creg_addr_t addr;
        word_t wd;
    } rf_w_t;

    typedef struct packed {
        logic [5:0] opcode;
        creg_addr_t rs;
        creg_addr_t rt;
        creg_addr_t rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_instr_t;

    typedef struct packed {
        logic [5:0] opcode;
        creg_addr_t rs;
        creg_addr_t rt;
        logic [15:0] imm;
    } i_instr_t;

    // same word, register-form or immediate-form fields
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDIU,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE
    } op_t;

endpackage
